/* common/mac_pkg.sv */
// Sizes assume a 64-line store, an 8-line direct-mapped cache, two ports and 4 in-flight slots.
package mac_pkg;

    // Port and line geometry.
    localparam int NUM_PORTS   = 2;
    localparam int PORT_W      = 1;
    localparam int LINE_ADDR_W = 6;
    localparam int LINE_W      = 128;

    // Cache geometry, index is the low address bits.
    localparam int INDEX_W = 3;
    localparam int TAG_W   = LINE_ADDR_W - INDEX_W;

    // In-flight table and L1 input queue.
    localparam int IFR_LEN   = 4;
    localparam int SLOT_W    = 2;
    localparam int QUEUE_LEN = 4;

    typedef enum logic {
        REQ_READ  = 1'b0,
        REQ_WRITE = 1'b1
    } req_kind_e;

    // One port's request.
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      data;
        req_kind_e              kind;
    } port_req_t;

    // Admitted request, tagged with where it came from and its table slot.
    typedef struct packed {
        port_req_t         req;
        logic [PORT_W-1:0] origin;
        logic [SLOT_W-1:0] slot;
    } mac_req_t;

    // Completed request; data is read data, or the written line for a write.
    typedef struct packed {
        logic [LINE_ADDR_W-1:0] addr;
        logic [LINE_W-1:0]      data;
        req_kind_e              kind;
        logic [PORT_W-1:0]      origin;
        logic [SLOT_W-1:0]      slot;
        logic                   hit;
    } mac_resp_t;

    typedef enum logic [2:0] {
        L1_IDLE,
        L1_LOOKUP,
        L1_WRITE_BACK,
        L1_FILL,
        L1_DONE
    } l1_state_e;

endpackage

/* l1_stage/l1_stage.sv */
// One request in the cache at a time; a dirty victim is written straight to the line store.
`timescale 1ns/1ps

module l1_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               issue_present,
    input  mac_pkg::mac_req_t  issue,
    output logic               issue_accept,
    output logic               done_present,
    output mac_pkg::mac_resp_t done,
    input  logic               done_accept
);
    import mac_pkg::*;

    // Input queue.
    mac_req_t                     q_mem [QUEUE_LEN];
    logic [$clog2(QUEUE_LEN)-1:0] q_wr_ptr;
    logic [$clog2(QUEUE_LEN)-1:0] q_rd_ptr;
    logic [$clog2(QUEUE_LEN):0]   q_count;
    logic                         q_push;
    logic                         q_pop;

    // Cache arrays.
    logic [2**INDEX_W-1:0] line_valid;
    logic [2**INDEX_W-1:0] line_dirty;
    logic [TAG_W-1:0]      line_tag  [2**INDEX_W];
    logic [LINE_W-1:0]     line_data [2**INDEX_W];

    // Active request and its result.
    l1_state_e         state;
    mac_req_t          cur;
    logic              hit_q;
    logic [LINE_W-1:0] result_data;

    logic [INDEX_W-1:0]     cur_index;
    logic [TAG_W-1:0]       cur_tag;
    logic                   lookup_hit;
    logic                   victim_dirty;
    logic                   install;
    logic                   install_dirty;
    logic [LINE_W-1:0]      install_data;
    logic [LINE_ADDR_W-1:0] wr_addr;
    logic [LINE_W-1:0]      rd_data;

    assign issue_accept = q_count != ($clog2(QUEUE_LEN) + 1)'(QUEUE_LEN);
    assign q_push       = issue_present && issue_accept;
    assign q_pop        = (state == L1_IDLE) && (q_count != '0);

    assign cur_index    = cur.req.addr[INDEX_W-1:0];
    assign cur_tag      = cur.req.addr[LINE_ADDR_W-1:INDEX_W];
    assign lookup_hit   = line_valid[cur_index] && (line_tag[cur_index] == cur_tag);
    assign victim_dirty = line_valid[cur_index] && line_dirty[cur_index];
    assign wr_addr      = {line_tag[cur_index], cur_index};

    // Which cycle writes the cache line, and with what.
    always_comb begin
        install       = 1'b0;
        install_dirty = 1'b1;
        install_data  = cur.req.data;
        case (state)
            // Write hit, or write miss over a clean victim.
            L1_LOOKUP:     install = (cur.req.kind == REQ_WRITE) && (lookup_hit || !victim_dirty);
            L1_WRITE_BACK: install = cur.req.kind == REQ_WRITE;
            L1_FILL: begin
                install       = 1'b1;
                install_dirty = 1'b0;
                install_data  = rd_data;
            end
            default:       install = 1'b0;
        endcase
    end

    // Store read follows the active address; data is ready in the cycle after lookup.
    line_store u_line_store (
        .clk     (clk),
        .rd_addr (cur.req.addr),
        .rd_data (rd_data),
        .wr_en   (state == L1_WRITE_BACK),
        .wr_addr (wr_addr),
        .wr_data (line_data[cur_index])
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= L1_IDLE;
            q_wr_ptr   <= '0;
            q_rd_ptr   <= '0;
            q_count    <= '0;
            line_valid <= '0;
            line_dirty <= '0;
            hit_q      <= 1'b0;
        end else begin
            if (q_push) begin
                q_wr_ptr <= q_wr_ptr + 1'b1;
            end
            if (q_pop) begin
                q_rd_ptr <= q_rd_ptr + 1'b1;
            end
            if (q_push && !q_pop) begin
                q_count <= q_count + 1'b1;
            end else if (q_pop && !q_push) begin
                q_count <= q_count - 1'b1;
            end
            if (install) begin
                line_valid[cur_index] <= 1'b1;
                line_dirty[cur_index] <= install_dirty;
            end
            case (state)
                L1_IDLE:   if (q_pop) state <= L1_LOOKUP;
                L1_LOOKUP: begin
                    hit_q <= lookup_hit;
                    if (lookup_hit) state <= L1_DONE;
                    else if (victim_dirty) state <= L1_WRITE_BACK;
                    else if (cur.req.kind == REQ_READ) state <= L1_FILL;
                    else state <= L1_DONE;
                end
                L1_WRITE_BACK: state <= (cur.req.kind == REQ_READ) ? L1_FILL : L1_DONE;
                L1_FILL:   state <= L1_DONE;
                L1_DONE:   if (done_accept) state <= L1_IDLE;
                default:   state <= L1_IDLE;
            endcase
        end
    end

    // Payload: queue slots, cache lines, active request, read result.
    always_ff @(posedge clk) begin
        if (q_push) q_mem[q_wr_ptr] <= issue;
        if (q_pop) cur <= q_mem[q_rd_ptr];
        if (install) begin
            line_tag[cur_index]  <= cur_tag;
            line_data[cur_index] <= install_data;
        end
        if (state == L1_LOOKUP) result_data <= line_data[cur_index];
        else if (state == L1_FILL) result_data <= rd_data;
    end

    assign done_present = state == L1_DONE;
    assign done.addr    = cur.req.addr;
    // A write returns the line it wrote.
    assign done.data    = (cur.req.kind == REQ_WRITE) ? cur.req.data : result_data;
    assign done.kind    = cur.req.kind;
    assign done.origin  = cur.origin;
    assign done.slot    = cur.slot;
    assign done.hit     = hit_q;

endmodule

/* l1_stage/line_store.sv */
// No reset; a read of a line never written returns undefined data, one cycle after the address.
`timescale 1ns/1ps

module line_store (
    input  logic                            clk,
    input  logic [mac_pkg::LINE_ADDR_W-1:0] rd_addr,
    output logic [mac_pkg::LINE_W-1:0]      rd_data,
    input  logic                            wr_en,
    input  logic [mac_pkg::LINE_ADDR_W-1:0] wr_addr,
    input  logic [mac_pkg::LINE_W-1:0]      wr_data
);
    import mac_pkg::*;

    // Backing lines, one per line address.
    logic [LINE_W-1:0] mem [2**LINE_ADDR_W];

    // Registered read.
    // Same-address write in the same cycle returns the old line.
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

    // Write-backs and dirty victims land here.
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

endmodule

/* mac.f */
common/mac_pkg.sv
l1_stage/line_store.sv
l1_stage/l1_stage.sv
source/mac_scheduler.sv
source/mac_return.sv
source/mac_top.sv
tb/mac_sva.sv
tb/mac_tb_clock.sv
tb/mac_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exits non-zero unless the run passed.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module mac_tb -f mac.f -o mac_sim

output=$(./obj_dir/mac_sim)
echo "$output"

if echo "$output" | grep -qx "test passed"; then
    exit 0
fi
echo "Simulation did not report a pass"
exit 1

/* source/mac_return.sv */
// Holds one response at a time; done is refused until the origin port takes the held one.
`timescale 1ns/1ps

module mac_return (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                done_present,
    input  mac_pkg::mac_resp_t                  done,
    output logic                                done_accept,
    output logic [mac_pkg::NUM_PORTS-1:0]       resp_present,
    output mac_pkg::mac_resp_t                  resp,
    input  logic [mac_pkg::NUM_PORTS-1:0]       resp_accept,
    output logic                                retire_valid,
    output logic [mac_pkg::SLOT_W-1:0]          retire_slot
);
    import mac_pkg::*;

    mac_resp_t held;
    logic      held_valid;
    logic      taken;

    // Room only when empty.
    assign done_accept = !held_valid;

    // Present only toward the origin port.
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            resp_present[p] = held_valid && (held.origin == PORT_W'(p));
        end
    end

    assign resp  = held;
    assign taken = held_valid && resp_accept[held.origin];

    // Retire pulse at the acceptance edge.
    assign retire_valid = taken;
    assign retire_slot  = held.slot;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_valid <= 1'b0;
        end else if (done_present && done_accept) begin
            held_valid <= 1'b1;
        end else if (taken) begin
            held_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (done_present && done_accept) begin
            held <= done;
        end
    end

endmodule

/* source/mac_scheduler.sv */
// Admits one request per cycle, port 0 first; a line in flight blocks any new request to it.
`timescale 1ns/1ps

module mac_scheduler (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [mac_pkg::NUM_PORTS-1:0]                  req_present,
    input  mac_pkg::port_req_t [mac_pkg::NUM_PORTS-1:0]    req,
    output logic [mac_pkg::NUM_PORTS-1:0]                  req_accept,
    output logic                                           issue_present,
    output mac_pkg::mac_req_t                              issue,
    input  logic                                           issue_accept,
    input  logic                                           retire_valid,
    input  logic [mac_pkg::SLOT_W-1:0]                     retire_slot
);
    import mac_pkg::*;

    // In-flight table.
    logic [LINE_ADDR_W-1:0] ifr_addr [IFR_LEN];
    logic [IFR_LEN-1:0]     ifr_used;

    logic [NUM_PORTS-1:0] clash;
    logic                 ifr_full;
    logic [SLOT_W-1:0]    free_slot;
    logic                 pick_valid;
    logic [PORT_W-1:0]    pick_port;
    logic                 admit;

    // A port clashes if any used entry holds its line.
    always_comb begin
        clash = '0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            for (int s = 0; s < IFR_LEN; s++) begin
                if (ifr_used[s] && ifr_addr[s] == req[p].addr) begin
                    clash[p] = 1'b1;
                end
            end
        end
    end

    // Lowest free slot, scanned from the top so the lowest wins.
    always_comb begin
        free_slot = '0;
        for (int s = IFR_LEN - 1; s >= 0; s--) begin
            if (!ifr_used[s]) begin
                free_slot = SLOT_W'(s);
            end
        end
    end

    assign ifr_full = &ifr_used;

    // Priority pick, lowest port number wins.
    always_comb begin
        pick_valid = 1'b0;
        pick_port  = '0;
        for (int p = NUM_PORTS - 1; p >= 0; p--) begin
            if (req_present[p] && !clash[p]) begin
                pick_valid = 1'b1;
                pick_port  = PORT_W'(p);
            end
        end
    end

    assign issue_present = pick_valid && !ifr_full;
    assign issue.req     = req[pick_port];
    assign issue.origin  = pick_port;
    assign issue.slot    = free_slot;
    assign admit         = issue_present && issue_accept;

    // Port sees accept only when the L1 stage takes the issue.
    always_comb begin
        for (int p = 0; p < NUM_PORTS; p++) begin
            req_accept[p] = admit && (pick_port == PORT_W'(p));
        end
    end

    // Used bits; admit never targets the retiring slot since it is still used.
    always_ff @(posedge clk) begin
        if (reset) begin
            ifr_used <= '0;
        end else begin
            if (retire_valid) begin
                ifr_used[retire_slot] <= 1'b0;
            end
            if (admit) begin
                ifr_used[free_slot] <= 1'b1;
            end
        end
    end

    // Addresses only matter while the used bit is set.
    always_ff @(posedge clk) begin
        if (admit) begin
            ifr_addr[free_slot] <= issue.req.addr;
        end
    end

endmodule

/* source/mac_top.sv */
// Responses share one bus; only the origin port sees present, and latency varies per request.
`timescale 1ns/1ps

module mac_top (
    input  logic                                           clk,
    input  logic                                           reset,
    input  logic [mac_pkg::NUM_PORTS-1:0]                  req_present,
    input  mac_pkg::port_req_t [mac_pkg::NUM_PORTS-1:0]    req,
    output logic [mac_pkg::NUM_PORTS-1:0]                  req_accept,
    output logic [mac_pkg::NUM_PORTS-1:0]                  resp_present,
    output mac_pkg::mac_resp_t                             resp,
    input  logic [mac_pkg::NUM_PORTS-1:0]                  resp_accept
);
    import mac_pkg::*;

    // Scheduler to L1 stage.
    logic      issue_present;
    mac_req_t  issue;
    logic      issue_accept;

    // L1 stage to return router.
    logic      done_present;
    mac_resp_t done;
    logic      done_accept;

    // Slot release back to the scheduler.
    logic              retire_valid;
    logic [SLOT_W-1:0] retire_slot;

    // Decode: arbitration and clash blocking.
    mac_scheduler u_scheduler (
        .clk           (clk),
        .reset         (reset),
        .req_present   (req_present),
        .req           (req),
        .req_accept    (req_accept),
        .issue_present (issue_present),
        .issue         (issue),
        .issue_accept  (issue_accept),
        .retire_valid  (retire_valid),
        .retire_slot   (retire_slot)
    );

    // Execute: queue and L1 cache.
    l1_stage u_l1_stage (
        .clk           (clk),
        .reset         (reset),
        .issue_present (issue_present),
        .issue         (issue),
        .issue_accept  (issue_accept),
        .done_present  (done_present),
        .done          (done),
        .done_accept   (done_accept)
    );

    // Result: route back to the origin port.
    mac_return u_return (
        .clk          (clk),
        .reset        (reset),
        .done_present (done_present),
        .done         (done),
        .done_accept  (done_accept),
        .resp_present (resp_present),
        .resp         (resp),
        .resp_accept  (resp_accept),
        .retire_valid (retire_valid),
        .retire_slot  (retire_slot)
    );

endmodule

/* tb/mac_sva.sv */
// Bound into the scheduler; keeps its own count of admitted requests, each assumed to retire once.
`timescale 1ns/1ps

module mac_sva (
    input logic                          clk,
    input logic                          reset,
    input logic [mac_pkg::NUM_PORTS-1:0] req_accept,
    input logic                          issue_present,
    input mac_pkg::mac_req_t             issue,
    input logic                          issue_accept,
    input logic                          retire_valid
);
    import mac_pkg::*;

    // Requests admitted and not yet retired.
    logic [SLOT_W:0] in_flight;

    always_ff @(posedge clk) begin
        if (reset) begin
            in_flight <= '0;
        end else begin
            in_flight <= in_flight + (SLOT_W + 1)'(|req_accept) - (SLOT_W + 1)'(retire_valid);
        end
    end

    // A stalled issue keeps both present and payload.
    issue_hold: assert property (@(posedge clk) disable iff (reset)
        issue_present && !issue_accept |=> issue_present && $stable(issue))
        else $error("Stalled issue changed before the L1 stage took it");

    // One admission per cycle at most.
    one_accept: assert property (@(posedge clk) disable iff (reset) $onehot0(req_accept))
        else $error("More than one port accepted in the same cycle");

    // No admission while every slot is in use.
    full_block: assert property (@(posedge clk) disable iff (reset)
        in_flight == (SLOT_W + 1)'(IFR_LEN) |-> req_accept == '0)
        else $error("Request accepted with every in-flight slot used");

endmodule

bind mac_scheduler mac_sva sva0 (
    .clk           (clk),
    .reset         (reset),
    .req_accept    (req_accept),
    .issue_present (issue_present),
    .issue         (issue),
    .issue_accept  (issue_accept),
    .retire_valid  (retire_valid)
);

/* tb/mac_tb.sv */
// Directed tests issue requests in program order; reads only target lines written earlier.
`timescale 1ns/1ps

module mac_tb;
    import mac_pkg::*;

    localparam int WAIT_LIMIT  = 100;
    localparam int CYCLE_LIMIT = 2000;

    logic                      clk;
    logic                      reset;
    logic [NUM_PORTS-1:0]      req_present;
    port_req_t [NUM_PORTS-1:0] req;
    logic [NUM_PORTS-1:0]      req_accept;
    logic [NUM_PORTS-1:0]      resp_present;
    mac_resp_t                 resp;
    logic [NUM_PORTS-1:0]      resp_accept;

    // Reference model: line contents plus a mirror of each index's valid bit and tag.
    logic [LINE_W-1:0]      ref_mem [2**LINE_ADDR_W];
    logic [2**INDEX_W-1:0]  ref_valid;
    logic [TAG_W-1:0]       ref_tag [2**INDEX_W];
    logic [LINE_ADDR_W-1:0] written [$];

    int cycles = 0;
    int errors = 0;
    int checks = 0;
    int tests  = 0;
    int accept_cycle [NUM_PORTS];

    mac_tb_clock clock0 (.clk(clk), .reset(reset));

    mac_top dut0 (
        .clk          (clk),
        .reset        (reset),
        .req_present  (req_present),
        .req          (req),
        .req_accept   (req_accept),
        .resp_present (resp_present),
        .resp         (resp),
        .resp_accept  (resp_accept)
    );

    // Run limit, about four times the longest sequence.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing", cycles);
            $display("test failed");
            $finish;
        end
    end

    task automatic check_data(input string tname, input logic [LINE_W-1:0] exp,
                              input logic [LINE_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: data expected %h, actual %h", tname, exp, act);
        end
    endtask

    task automatic check_hit(input string tname, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: hit expected %b, actual %b", tname, exp, act);
        end
    endtask

    task automatic check_port(input string tname, input logic [PORT_W-1:0] exp,
                              input logic [PORT_W-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("[ERROR] %s: port expected %0d, actual %0d", tname, exp, act);
        end
    endtask

    // Hit if the index holds this tag; every access leaves its line cached.
    function automatic void model_access(input port_req_t r, output logic [LINE_W-1:0] d,
                                         output logic h);
        logic [INDEX_W-1:0] idx;
        logic [TAG_W-1:0]   tg;
        idx = r.addr[INDEX_W-1:0];
        tg  = r.addr[LINE_ADDR_W-1:INDEX_W];
        h   = ref_valid[idx] && (ref_tag[idx] == tg);
        if (r.kind == REQ_WRITE) begin
            ref_mem[r.addr] = r.data;
            written.push_back(r.addr);
        end
        d = ref_mem[r.addr];
        ref_valid[idx] = 1'b1;
        ref_tag[idx]   = tg;
    endfunction

    function automatic port_req_t make_req(input logic [LINE_ADDR_W-1:0] addr,
                                           input req_kind_e kind);
        port_req_t r;
        r.addr = addr;
        r.kind = kind;
        r.data = {$urandom, $urandom, $urandom, $urandom};
        return r;
    endfunction

    // Called at edge plus 1 ns; drops present 1 ns after the accepting edge.
    task automatic wait_accept(input int p, input string tname);
        int n;
        n = 0;
        while (n < WAIT_LIMIT) begin
            @(negedge clk);
            if (req_accept[p]) break;
            n++;
        end
        if (n == WAIT_LIMIT) begin
            errors++;
            $display("Timeout: port %0d request never accepted in %s", p, tname);
        end else begin
            accept_cycle[p] = cycles;
        end
        @(posedge clk);
        #1;
        req_present[p] = 1'b0;
    endtask

    task automatic send(input int p, input port_req_t r, input string tname);
        req[p]         = r;
        req_present[p] = 1'b1;
        wait_accept(p, tname);
    endtask

    // Samples mid-cycle once the line's response is present on any port, then realigns.
    task automatic collect(input int p, input string tname,
                           input logic [LINE_ADDR_W-1:0] exp_addr,
                           input logic [LINE_W-1:0] exp_data, input logic exp_hit);
        int                n;
        mac_resp_t         got;
        logic [PORT_W-1:0] got_port;
        n        = 0;
        got_port = '0;
        while (n < WAIT_LIMIT) begin
            @(negedge clk);
            if (resp_present != '0 && resp.addr == exp_addr) break;
            n++;
        end
        if (n == WAIT_LIMIT) begin
            errors++;
            $display("Timeout: no response for line %0d in %s", exp_addr, tname);
        end else begin
            got = resp;
            // Arrival port is the one whose present is high.
            for (int q = 0; q < NUM_PORTS; q++) begin
                if (resp_present[q]) begin
                    got_port = PORT_W'(q);
                end
            end
            check_data(tname, exp_data, got.data);
            check_hit(tname, exp_hit, got.hit);
            check_port(tname, PORT_W'(p), got_port);
            check_port(tname, PORT_W'(p), got.origin);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic run_access(input int p, input port_req_t r, input string tname);
        logic [LINE_W-1:0] exp_data;
        logic              exp_hit;
        model_access(r, exp_data, exp_hit);
        send(p, r, tname);
        collect(p, tname, r.addr, exp_data, exp_hit);
    endtask

    task automatic finish_test(input string tname, input int err_before);
        tests++;
        if (errors == err_before) begin
            $display("%s: ok", tname);
        end else begin
            $display("%s: %0d errors", tname, errors - err_before);
        end
    endtask

    // Write miss, then read hit of the same line.
    task automatic write_then_read();
        int e;
        e = errors;
        run_access(0, make_req(6'd5, REQ_WRITE), "write_then_read");
        run_access(0, make_req(6'd5, REQ_READ), "write_then_read");
        finish_test("write_then_read", e);
    endtask

    // Lines 2 and 10 share index 2; the dirty line 2 must come back from the store.
    task automatic evict_dirty();
        int e;
        e = errors;
        run_access(0, make_req(6'd2, REQ_WRITE), "evict_dirty");
        run_access(0, make_req(6'd10, REQ_WRITE), "evict_dirty");
        run_access(0, make_req(6'd2, REQ_READ), "evict_dirty");
        finish_test("evict_dirty", e);
    endtask

    // Same-cycle requests; port 0 wins, port 1 follows.
    task automatic two_port_race();
        int                e;
        port_req_t         r0;
        port_req_t         r1;
        logic [LINE_W-1:0] d0;
        logic [LINE_W-1:0] d1;
        logic              h0;
        logic              h1;
        e  = errors;
        r0 = make_req(6'd33, REQ_WRITE);
        r1 = make_req(6'd12, REQ_WRITE);
        model_access(r0, d0, h0);
        model_access(r1, d1, h1);
        fork
            begin
                send(0, r0, "two_port_race");
                collect(0, "two_port_race", r0.addr, d0, h0);
            end
            begin
                send(1, r1, "two_port_race");
                collect(1, "two_port_race", r1.addr, d1, h1);
            end
        join
        checks++;
        if (accept_cycle[0] >= accept_cycle[1]) begin
            errors++;
            $display("Port 1 was accepted no later than port 0 in two_port_race");
        end
        finish_test("two_port_race", e);
    endtask

    // Port 1 wants the line port 0 holds; it waits until port 0's response is taken.
    task automatic line_clash();
        int                e;
        int                release_cycle;
        logic              watching;
        port_req_t         r0;
        port_req_t         r1;
        logic [LINE_W-1:0] d0;
        logic [LINE_W-1:0] d1;
        logic              h0;
        logic              h1;
        e  = errors;
        r0 = make_req(6'd20, REQ_WRITE);
        r1 = make_req(6'd20, REQ_READ);
        model_access(r0, d0, h0);
        model_access(r1, d1, h1);
        resp_accept[0] = 1'b0;
        req[1]         = r1;
        req_present[1] = 1'b1;
        watching       = 1'b1;
        fork
            begin
                send(0, r0, "line_clash");
                collect(0, "line_clash", r0.addr, d0, h0);
                repeat (4) @(posedge clk);
                watching = 1'b0;
            end
            // Port 1 stays blocked for as long as port 0 holds the line.
            while (watching) begin
                @(negedge clk);
                checks++;
                if (req_accept[1]) begin
                    errors++;
                    $display("Port 1 accepted while its line was in flight in line_clash");
                end
            end
        join
        @(posedge clk);
        #1;
        resp_accept[0] = 1'b1;
        release_cycle  = cycles;
        wait_accept(1, "line_clash");
        collect(1, "line_clash", r1.addr, d1, h1);
        checks++;
        if (accept_cycle[1] <= release_cycle) begin
            errors++;
            $display("Port 1 accepted before port 0's response was taken in line_clash");
        end
        finish_test("line_clash", e);
    endtask

    // Four slots fill while responses are refused; the fifth waits for a retire.
    task automatic slot_limit();
        int                e;
        port_req_t         r [5];
        logic [LINE_W-1:0] d [5];
        logic              h [5];
        e = errors;
        resp_accept = '0;
        for (int k = 0; k < 5; k++) begin
            r[k] = make_req(LINE_ADDR_W'(40 + k), REQ_WRITE);
            model_access(r[k], d[k], h[k]);
        end
        for (int k = 0; k < 4; k++) begin
            send(0, r[k], "slot_limit");
        end
        req[0]         = r[4];
        req_present[0] = 1'b1;
        repeat (20) begin
            @(negedge clk);
            checks++;
            if (req_accept[0]) begin
                errors++;
                $display("Fifth request accepted with all slots in use in slot_limit");
            end
        end
        @(posedge clk);
        #1;
        resp_accept = '1;
        fork
            wait_accept(0, "slot_limit");
            begin
                for (int k = 0; k < 5; k++) begin
                    collect(0, "slot_limit", r[k].addr, d[k], h[k]);
                end
            end
        join
        finish_test("slot_limit", e);
    endtask

    // One request at a time keeps the model in step with the DUT's order.
    task automatic random_mix();
        int                     e;
        int                     p;
        logic [LINE_ADDR_W-1:0] addr;
        port_req_t              r;
        e = errors;
        for (int i = 0; i < 40; i++) begin
            p = int'($urandom_range(1, 0));
            if (written.size() == 0 || $urandom_range(1, 0) == 1) begin
                addr = LINE_ADDR_W'($urandom_range(15, 0));
                r    = make_req(addr, REQ_WRITE);
            end else begin
                addr = written[$urandom_range(written.size() - 1, 0)];
                r    = make_req(addr, REQ_READ);
            end
            run_access(p, r, "random_mix");
        end
        finish_test("random_mix", e);
    endtask

    initial begin
        void'($urandom(74044));
        req_present = '0;
        req         = '0;
        resp_accept = '1;
        ref_valid   = '0;
        @(negedge reset);
        @(posedge clk);
        #1;
        write_then_read();
        evict_dirty();
        two_port_race();
        line_clash();
        slot_limit();
        random_mix();
        $display("Tests: %0d, checks: %0d, errors: %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* tb/mac_tb_clock.sv */
// Free-running 4 ns clock; reset is held high for the first 4 rising edges.
`timescale 1ns/1ps

module mac_tb_clock (
    output logic clk,
    output logic reset
);

    // Half period of 2 ns.
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Release 1 ns after the fourth edge, in step with the stimulus.
    initial begin
        reset = 1'b1;
        repeat (4) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule
